// File: hdl/harness_pkg.sv
/* I/O space is 20 bits with the host registers at the top. Everything below
   HOST_BASE is backing memory of 64-bit words. */
`default_nettype none

package harness_pkg;

  typedef logic [19:0] io_addr_t;
  typedef logic [63:0] io_data_t;

  typedef enum logic
  {
    e_io_read  = 1'b0,
    e_io_write = 1'b1
  } io_op_e;

  typedef struct packed
  {
    io_op_e   op;
    io_addr_t addr;
    io_data_t data;
  } io_cmd_s;

  // Write responses carry zero data
  typedef struct packed
  {
    io_op_e   op;
    io_addr_t addr;
    io_data_t data;
  } io_resp_s;

  typedef enum logic [1:0]
  {
    e_nbf_write  = 2'b00,
    e_nbf_fence  = 2'b01,
    e_nbf_finish = 2'b10
  } nbf_op_e;

  typedef struct packed
  {
    nbf_op_e  opcode;
    io_addr_t addr;
    io_data_t data;
  } nbf_pkt_s;

  typedef struct packed
  {
    logic icache_trace;
    logic dcache_trace;
    logic cmt_trace;
    logic vm_trace;
    logic core_profile;
    logic pc_profile;
    logic branch_profile;
    logic cosim;
  } host_enables_s;

  localparam io_addr_t HOST_BASE         = 20'hf_0000;
  localparam io_addr_t HOST_ENABLES_ADDR = 20'hf_0000;
  localparam io_addr_t HOST_FINISH_ADDR  = 20'hf_0008;

  // Byte offset bits below the memory word index
  localparam int MEM_OFFSET_BITS = 3;

endpackage

`default_nettype wire

// File: hdl/nbf_loader.sv
/* Issues one write at a time and never more than 255 unacknowledged writes.
   Packets after finish are not accepted. */
`timescale 1ns/1ns
`default_nettype none

module nbf_loader
  (input  logic                  clk_i
  ,input  logic                  reset_i

  ,input  harness_pkg::nbf_pkt_s nbf_i
  ,input  logic                  nbf_v_i
  ,output logic                  nbf_ready_o

  ,output harness_pkg::io_cmd_s  cmd_o
  ,output logic                  cmd_v_o
  ,input  logic                  cmd_ready_i

  ,input  logic                  resp_v_i
  ,output logic                  done_o
  );

  import harness_pkg::*;

  localparam int cnt_w_lp = 8;

  typedef enum logic [1:0]
  {
    e_idle,
    e_issue,
    e_drain,
    e_done
  } state_e;

  state_e              state_r, state_n;
  io_cmd_s             cmd_r;
  logic [cnt_w_lp-1:0] out_cnt_r;
  logic                fin_r;
  logic                nbf_fire, cmd_fire;

  assign nbf_ready_o = (state_r == e_idle);
  assign cmd_v_o     = (state_r == e_issue);
  assign done_o      = (state_r == e_done);
  assign cmd_o       = cmd_r;

  assign nbf_fire = nbf_v_i & nbf_ready_o;
  assign cmd_fire = cmd_v_o & cmd_ready_i;

  always_comb
  begin
    state_n = state_r;
    case (state_r)
      e_idle:
        if (nbf_fire)
          state_n = (nbf_i.opcode == e_nbf_write) ? e_issue : e_drain;
      e_issue:
        if (cmd_ready_i)
          state_n = e_idle;
      // Fence and finish both wait for every write to be acknowledged
      e_drain:
        if (out_cnt_r == '0)
          state_n = fin_r ? e_done : e_idle;
      default:
        state_n = e_done;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r   <= e_idle;
      out_cnt_r <= '0;
      fin_r     <= 1'b0;
    end
    else
    begin
      state_r   <= state_n;
      out_cnt_r <= out_cnt_r + cnt_w_lp'(cmd_fire) - cnt_w_lp'(resp_v_i);
      if (nbf_fire && nbf_i.opcode == e_nbf_finish)
        fin_r <= 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (nbf_fire)
    begin
      cmd_r.op   <= e_io_write;
      cmd_r.addr <= nbf_i.addr;
      cmd_r.data <= nbf_i.data;
    end
  end

  // Every acknowledgement from the switch matches a counted write
  assert property (@(posedge clk_i) disable iff (reset_i)
                   resp_v_i |-> (out_cnt_r != '0));

endmodule

`default_nettype wire

// File: hdl/io_switch.sv
/* Targets must answer their own commands in order. Command ready may depend
   on command valid through the arbiter. */
`timescale 1ns/1ns
`default_nettype none

module io_switch
  #(parameter int max_outstanding_p = 4)
  (input  logic                  clk_i
  ,input  logic                  reset_i

  ,input  harness_pkg::io_cmd_s  proc_cmd_i
  ,input  logic                  proc_cmd_v_i
  ,output logic                  proc_cmd_ready_o
  ,output harness_pkg::io_resp_s proc_resp_o
  ,output logic                  proc_resp_v_o
  ,input  logic                  proc_resp_ready_i

  ,input  harness_pkg::io_cmd_s  load_cmd_i
  ,input  logic                  load_cmd_v_i
  ,output logic                  load_cmd_ready_o
  ,output harness_pkg::io_resp_s load_resp_o
  ,output logic                  load_resp_v_o

  ,output harness_pkg::io_cmd_s  host_cmd_o
  ,output logic                  host_cmd_v_o
  ,input  logic                  host_cmd_ready_i
  ,input  harness_pkg::io_resp_s host_resp_i
  ,input  logic                  host_resp_v_i
  ,output logic                  host_resp_ready_o

  ,output harness_pkg::io_cmd_s  mem_cmd_o
  ,output logic                  mem_cmd_v_o
  ,input  logic                  mem_cmd_ready_i
  ,input  harness_pkg::io_resp_s mem_resp_i
  ,input  logic                  mem_resp_v_i
  ,output logic                  mem_resp_ready_o
  );

  import harness_pkg::*;

  localparam int ptr_w_lp = (max_outstanding_p > 1) ? $clog2(max_outstanding_p) : 1;
  localparam int cnt_w_lp = $clog2(max_outstanding_p + 1);

  typedef enum logic {e_src_proc, e_src_load} src_e;
  typedef enum logic {e_tgt_mem, e_tgt_host} tgt_e;

  typedef struct packed
  {
    src_e src;
    tgt_e tgt;
  } route_s;

  route_s              q_r [max_outstanding_p];
  logic [ptr_w_lp-1:0] wr_ptr_r, rd_ptr_r;
  logic [cnt_w_lp-1:0] q_cnt_r;
  src_e                last_grant_r, pend_src_r;
  logic                pend_r;
  logic                q_full, q_empty, push, pop;
  logic                sel_load, sel_v, tgt_host, tgt_ready;
  logic                head_host, resp_v_sel, dst_ready;
  io_cmd_s             sel_cmd;
  io_resp_s            resp_sel;
  route_s              grant_route, head;

  function automatic logic [ptr_w_lp-1:0] next_ptr(input logic [ptr_w_lp-1:0] ptr);
    if (ptr == ptr_w_lp'(max_outstanding_p - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  assign q_full  = (q_cnt_r == cnt_w_lp'(max_outstanding_p));
  assign q_empty = (q_cnt_r == '0);

  // A command shown to a target keeps its grant until it transfers
  always_comb
  begin
    if (pend_r)
      sel_load = (pend_src_r == e_src_load);
    else if (proc_cmd_v_i && load_cmd_v_i)
      sel_load = (last_grant_r == e_src_proc);
    else
      sel_load = load_cmd_v_i;
  end

  assign sel_cmd   = sel_load ? load_cmd_i : proc_cmd_i;
  assign sel_v     = sel_load ? load_cmd_v_i : proc_cmd_v_i;
  assign tgt_host  = (sel_cmd.addr >= HOST_BASE);
  assign tgt_ready = tgt_host ? host_cmd_ready_i : mem_cmd_ready_i;
  assign push      = sel_v & tgt_ready & ~q_full;

  assign grant_route.src = sel_load ? e_src_load : e_src_proc;
  assign grant_route.tgt = tgt_host ? e_tgt_host : e_tgt_mem;

  assign host_cmd_o       = sel_cmd;
  assign mem_cmd_o        = sel_cmd;
  assign host_cmd_v_o     = sel_v & tgt_host & ~q_full;
  assign mem_cmd_v_o      = sel_v & ~tgt_host & ~q_full;
  assign proc_cmd_ready_o = ~sel_load & tgt_ready & ~q_full;
  assign load_cmd_ready_o = sel_load & tgt_ready & ~q_full;

  // Only the target at the queue head may answer
  assign head       = q_r[rd_ptr_r];
  assign head_host  = (head.tgt == e_tgt_host);
  assign resp_sel   = head_host ? host_resp_i : mem_resp_i;
  assign resp_v_sel = ~q_empty & (head_host ? host_resp_v_i : mem_resp_v_i);
  assign dst_ready  = (head.src == e_src_proc) ? proc_resp_ready_i : 1'b1;
  assign pop        = resp_v_sel & dst_ready;

  assign proc_resp_o       = resp_sel;
  assign load_resp_o       = resp_sel;
  assign proc_resp_v_o     = resp_v_sel & (head.src == e_src_proc);
  assign load_resp_v_o     = resp_v_sel & (head.src == e_src_load);
  assign host_resp_ready_o = ~q_empty & head_host & dst_ready;
  assign mem_resp_ready_o  = ~q_empty & ~head_host & dst_ready;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      last_grant_r <= e_src_load;
      pend_r       <= 1'b0;
      pend_src_r   <= e_src_proc;
      wr_ptr_r     <= '0;
      rd_ptr_r     <= '0;
      q_cnt_r      <= '0;
    end
    else
    begin
      pend_r     <= sel_v & ~q_full & ~tgt_ready;
      pend_src_r <= grant_route.src;
      if (push)
      begin
        last_grant_r <= grant_route.src;
        wr_ptr_r     <= next_ptr(wr_ptr_r);
      end
      if (pop)
        rd_ptr_r <= next_ptr(rd_ptr_r);
      q_cnt_r <= q_cnt_r + cnt_w_lp'(push) - cnt_w_lp'(pop);
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (push)
      q_r[wr_ptr_r] <= grant_route;
  end

  // A push never lands on the head entry that still waits for its response
  assert property (@(posedge clk_i) disable iff (reset_i)
                   push |-> (q_empty || wr_ptr_r != rd_ptr_r));

  // A target never answers a command the switch did not send
  assert property (@(posedge clk_i) disable iff (reset_i)
                   (host_resp_v_i | mem_resp_v_i) |-> !q_empty);

endmodule

`default_nettype wire

// File: hdl/host_regs.sv
/* Decodes full host addresses only. Unknown addresses read zero and ignore
   writes. Finish stays set until reset. */
`timescale 1ns/1ns
`default_nettype none

module host_regs
  (input  logic                       clk_i
  ,input  logic                       reset_i

  ,input  harness_pkg::io_cmd_s       cmd_i
  ,input  logic                       cmd_v_i
  ,output logic                       cmd_ready_o

  ,output harness_pkg::io_resp_s      resp_o
  ,output logic                       resp_v_o
  ,input  logic                       resp_ready_i

  ,output harness_pkg::host_enables_s enables_o
  ,output logic                       finish_o
  );

  import harness_pkg::*;

  host_enables_s enables_r;
  logic          finish_r;
  io_resp_s      resp_r;
  logic          resp_v_r;
  logic          cmd_fire, is_write;
  io_data_t      rd_data;

  assign cmd_ready_o = ~resp_v_r | resp_ready_i;
  assign cmd_fire    = cmd_v_i & cmd_ready_o;
  assign is_write    = (cmd_i.op == e_io_write);

  always_comb
  begin
    case (cmd_i.addr)
      HOST_ENABLES_ADDR: rd_data = io_data_t'(enables_r);
      HOST_FINISH_ADDR:  rd_data = io_data_t'(finish_r);
      default:           rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      enables_r <= '0;
      finish_r  <= 1'b0;
      resp_v_r  <= 1'b0;
    end
    else
    begin
      if (cmd_fire)
        resp_v_r <= 1'b1;
      else if (resp_ready_i)
        resp_v_r <= 1'b0;
      if (cmd_fire && is_write && cmd_i.addr == HOST_ENABLES_ADDR)
        enables_r <= host_enables_s'(cmd_i.data[$bits(host_enables_s)-1:0]);
      if (cmd_fire && is_write && cmd_i.addr == HOST_FINISH_ADDR && cmd_i.data != '0)
        finish_r <= 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_fire)
    begin
      resp_r.op   <= cmd_i.op;
      resp_r.addr <= cmd_i.addr;
      resp_r.data <= is_write ? '0 : rd_data;
    end
  end

  assign resp_o    = resp_r;
  assign resp_v_o  = resp_v_r;
  assign enables_o = enables_r;
  assign finish_o  = finish_r;

endmodule

`default_nettype wire

// File: hdl/backing_mem.sv
/* Contents start undefined and the depth must be at least 2 words. Addresses
   wrap modulo the depth. */
`timescale 1ns/1ns
`default_nettype none

module backing_mem
  #(parameter int mem_words_p = 256)
  (input  logic                  clk_i
  ,input  logic                  reset_i

  ,input  harness_pkg::io_cmd_s  cmd_i
  ,input  logic                  cmd_v_i
  ,output logic                  cmd_ready_o

  ,output harness_pkg::io_resp_s resp_o
  ,output logic                  resp_v_o
  ,input  logic                  resp_ready_i
  );

  import harness_pkg::*;

  localparam int idx_w_lp = $clog2(mem_words_p);

  io_data_t            mem_r [mem_words_p];
  io_resp_s            resp_r;
  logic                resp_v_r;
  logic                cmd_fire;
  logic [idx_w_lp-1:0] idx;

  assign cmd_ready_o = ~resp_v_r | resp_ready_i;
  assign cmd_fire    = cmd_v_i & cmd_ready_o;
  assign idx         = idx_w_lp'((cmd_i.addr >> MEM_OFFSET_BITS) % mem_words_p);

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      resp_v_r <= 1'b0;
    else if (cmd_fire)
      resp_v_r <= 1'b1;
    else if (resp_ready_i)
      resp_v_r <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_fire)
    begin
      resp_r.op   <= cmd_i.op;
      resp_r.addr <= cmd_i.addr;
      if (cmd_i.op == e_io_write)
      begin
        mem_r[idx]  <= cmd_i.data;
        resp_r.data <= '0;
      end
      else
        resp_r.data <= mem_r[idx];
    end
  end

  assign resp_o   = resp_r;
  assign resp_v_o = resp_v_r;

  assert property (@(posedge clk_i) disable iff (reset_i)
                   (resp_v_o && !resp_ready_i) |=> (resp_v_o && $stable(resp_o)));

endmodule

`default_nettype wire

// File: hdl/harness_top.sv
/* Loader and processor port share one switch. Memory depth and the number of
   commands in flight are set here. */
`timescale 1ns/1ns
`default_nettype none

module harness_top
  #(parameter int mem_words_p       = 256
   ,parameter int max_outstanding_p = 4
   )
  (input  logic                       clk_i
  ,input  logic                       reset_i

  ,input  harness_pkg::nbf_pkt_s      nbf_i
  ,input  logic                       nbf_v_i
  ,output logic                       nbf_ready_o

  ,input  harness_pkg::io_cmd_s       proc_cmd_i
  ,input  logic                       proc_cmd_v_i
  ,output logic                       proc_cmd_ready_o

  ,output harness_pkg::io_resp_s      proc_resp_o
  ,output logic                       proc_resp_v_o
  ,input  logic                       proc_resp_ready_i

  ,output harness_pkg::host_enables_s enables_o
  ,output logic                       finish_o
  ,output logic                       load_done_o
  );

  import harness_pkg::*;

  io_cmd_s  load_cmd;
  logic     load_cmd_v, load_cmd_ready;
  logic     load_resp_v;

  io_cmd_s  host_cmd, mem_cmd;
  logic     host_cmd_v, host_cmd_ready, mem_cmd_v, mem_cmd_ready;
  io_resp_s host_resp, mem_resp;
  logic     host_resp_v, host_resp_ready, mem_resp_v, mem_resp_ready;

  nbf_loader loader
    (.clk_i(clk_i), .reset_i(reset_i)
    ,.nbf_i(nbf_i), .nbf_v_i(nbf_v_i), .nbf_ready_o(nbf_ready_o)
    ,.cmd_o(load_cmd), .cmd_v_o(load_cmd_v), .cmd_ready_i(load_cmd_ready)
    ,.resp_v_i(load_resp_v)
    ,.done_o(load_done_o)
    );

  // The loader only counts acknowledgements, so the response payload is dropped
  io_switch #(.max_outstanding_p(max_outstanding_p)) switch
    (.clk_i(clk_i), .reset_i(reset_i)
    ,.proc_cmd_i(proc_cmd_i), .proc_cmd_v_i(proc_cmd_v_i), .proc_cmd_ready_o(proc_cmd_ready_o)
    ,.proc_resp_o(proc_resp_o), .proc_resp_v_o(proc_resp_v_o)
    ,.proc_resp_ready_i(proc_resp_ready_i)
    ,.load_cmd_i(load_cmd), .load_cmd_v_i(load_cmd_v), .load_cmd_ready_o(load_cmd_ready)
    ,.load_resp_o(), .load_resp_v_o(load_resp_v)
    ,.host_cmd_o(host_cmd), .host_cmd_v_o(host_cmd_v), .host_cmd_ready_i(host_cmd_ready)
    ,.host_resp_i(host_resp), .host_resp_v_i(host_resp_v), .host_resp_ready_o(host_resp_ready)
    ,.mem_cmd_o(mem_cmd), .mem_cmd_v_o(mem_cmd_v), .mem_cmd_ready_i(mem_cmd_ready)
    ,.mem_resp_i(mem_resp), .mem_resp_v_i(mem_resp_v), .mem_resp_ready_o(mem_resp_ready)
    );

  host_regs host
    (.clk_i(clk_i), .reset_i(reset_i)
    ,.cmd_i(host_cmd), .cmd_v_i(host_cmd_v), .cmd_ready_o(host_cmd_ready)
    ,.resp_o(host_resp), .resp_v_o(host_resp_v), .resp_ready_i(host_resp_ready)
    ,.enables_o(enables_o), .finish_o(finish_o)
    );

  backing_mem #(.mem_words_p(mem_words_p)) mem
    (.clk_i(clk_i), .reset_i(reset_i)
    ,.cmd_i(mem_cmd), .cmd_v_i(mem_cmd_v), .cmd_ready_o(mem_cmd_ready)
    ,.resp_o(mem_resp), .resp_v_o(mem_resp_v), .resp_ready_i(mem_resp_ready)
    );

endmodule

`default_nettype wire

// File: verif/tb_clock_gen.sv
/* Free-running 10 ns clock, starting low */
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen
  (output logic clk_o
  );

  initial
  begin
    clk_o = 1'b0;
  end

  always #5 clk_o = ~clk_o;

endmodule

`default_nettype wire

// File: verif/harness_tb.sv
/* Needs verif/harness_golden.txt relative to the run directory. Loader and
   processor records run as two concurrent streams and must touch disjoint words. */
`timescale 1ns/1ns
`default_nettype none

module harness_tb;

  import harness_pkg::*;

  localparam int reset_cycles_lp = 16;
  localparam int max_recs_lp     = 64;
  localparam int cycles_per_rec_lp = 40;
  localparam int mem_words_lp    = 256;

  // Record kinds in the golden file
  localparam logic [3:0] load_write_k  = 4'h0;
  localparam logic [3:0] load_fence_k  = 4'h1;
  localparam logic [3:0] load_finish_k = 4'h2;
  localparam logic [3:0] proc_write_k  = 4'h3;
  localparam logic [3:0] proc_read_k   = 4'h4;
  localparam logic [3:0] wait_done_k   = 4'h5;
  localparam logic [3:0] end_k         = 4'hf;

  typedef struct packed
  {
    io_cmd_s  cmd;
    io_data_t exp_data;
  } pending_s;

  logic          clk, reset;
  nbf_pkt_s      nbf_i;
  logic          nbf_v_i, nbf_ready_o;
  io_cmd_s       proc_cmd_i;
  logic          proc_cmd_v_i, proc_cmd_ready_o;
  io_resp_s      proc_resp_o;
  logic          proc_resp_v_o, proc_resp_ready_i;
  host_enables_s enables_o;
  logic          finish_o, load_done_o;

  logic [63:0]   golden_r [0:3*max_recs_lp-1];
  int            rec_count;
  pending_s      exp_q [$];
  logic          checking, done_seen, finish_exp;
  logic [7:0]    enables_exp;

  tb_clock_gen clock_gen (.clk_o(clk));

  harness_top #(.mem_words_p(mem_words_lp), .max_outstanding_p(4)) uut
    (.clk_i(clk), .reset_i(reset)
    ,.nbf_i(nbf_i), .nbf_v_i(nbf_v_i), .nbf_ready_o(nbf_ready_o)
    ,.proc_cmd_i(proc_cmd_i), .proc_cmd_v_i(proc_cmd_v_i), .proc_cmd_ready_o(proc_cmd_ready_o)
    ,.proc_resp_o(proc_resp_o), .proc_resp_v_o(proc_resp_v_o)
    ,.proc_resp_ready_i(proc_resp_ready_i)
    ,.enables_o(enables_o), .finish_o(finish_o), .load_done_o(load_done_o)
    );

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Test failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] exp,
                                 input logic [63:0] got);
    report_failure($sformatf("Mismatch at %0t ns: %s expected %h, got %h",
                             $time, name, exp, got));
  endtask

  // Holds the packet until the loader takes it
  task automatic send_packet(input nbf_pkt_s pkt);
    @(negedge clk);
    nbf_i   = pkt;
    nbf_v_i = 1'b1;
    #1;
    while (!nbf_ready_o)
    begin
      @(negedge clk);
      #1;
    end
  endtask

  task automatic send_command(input io_cmd_s cmd, input io_data_t exp_data);
    pending_s p;
    @(negedge clk);
    proc_cmd_i   = cmd;
    proc_cmd_v_i = 1'b1;
    #1;
    while (!proc_cmd_ready_o)
    begin
      @(negedge clk);
      #1;
    end
    p.cmd      = cmd;
    p.exp_data = (cmd.op == e_io_write) ? '0 : exp_data;
    exp_q.push_back(p);
  endtask

  task automatic run_loader();
    logic [3:0] kind;
    nbf_pkt_s   pkt;
    for (int i = 0; i < rec_count; i++)
    begin
      kind = golden_r[3*i][3:0];
      if (kind == load_write_k || kind == load_fence_k || kind == load_finish_k)
      begin
        pkt.opcode = nbf_op_e'(kind[1:0]);
        pkt.addr   = golden_r[3*i+1][19:0];
        pkt.data   = golden_r[3*i+2];
        send_packet(pkt);
      end
    end
    @(negedge clk);
    nbf_v_i = 1'b0;
  endtask

  task automatic run_processor();
    logic [3:0] kind;
    io_cmd_s    cmd;
    for (int i = 0; i < rec_count; i++)
    begin
      kind     = golden_r[3*i][3:0];
      cmd.addr = golden_r[3*i+1][19:0];
      cmd.data = (kind == proc_write_k) ? golden_r[3*i+2] : '0;
      if (kind == proc_write_k || kind == proc_read_k)
      begin
        cmd.op = (kind == proc_write_k) ? e_io_write : e_io_read;
        send_command(cmd, golden_r[3*i+2]);
      end
      else if (kind == wait_done_k)
      begin
        @(negedge clk);
        proc_cmd_v_i = 1'b0;
        #1;
        while (!load_done_o)
        begin
          @(negedge clk);
          #1;
        end
      end
    end
    @(negedge clk);
    proc_cmd_v_i = 1'b0;
  endtask

  // Every loader write must already sit in its memory word when done rises
  task automatic check_loaded_words();
    logic [19:0] addr;
    int          idx;
    for (int i = 0; i < rec_count; i++)
    begin
      if (golden_r[3*i][3:0] == load_write_k)
      begin
        addr = golden_r[3*i+1][19:0];
        idx  = int'(addr >> 3) % mem_words_lp;
        assert (uut.mem.mem_r[idx] == golden_r[3*i+2])
          else report_mismatch($sformatf("uut.mem.mem_r[%0d]", idx),
                               golden_r[3*i+2], uut.mem.mem_r[idx]);
      end
    end
  endtask

  task automatic check_response();
    pending_s p;
    assert (exp_q.size() != 0)
      else report_failure("Response on the processor port with no command pending");
    p = exp_q.pop_front();
    assert (proc_resp_o.op == p.cmd.op)
      else report_mismatch("proc_resp_o.op", 64'(p.cmd.op), 64'(proc_resp_o.op));
    assert (proc_resp_o.addr == p.cmd.addr)
      else report_mismatch("proc_resp_o.addr", 64'(p.cmd.addr), 64'(proc_resp_o.addr));
    assert (proc_resp_o.data == p.exp_data)
      else report_mismatch("proc_resp_o.data", p.exp_data, proc_resp_o.data);
    if (p.cmd.op == e_io_write && p.cmd.addr == HOST_ENABLES_ADDR)
    begin
      enables_exp = p.cmd.data[7:0];
      assert (enables_o == enables_exp)
        else report_mismatch("enables_o", 64'(enables_exp), 64'(enables_o));
    end
    if (p.cmd.op == e_io_write && p.cmd.addr == HOST_FINISH_ADDR && p.cmd.data != '0)
      finish_exp = 1'b1;
  endtask

  // Responses and sticky outputs are sampled 1 ns after the falling edge
  always @(negedge clk)
  begin
    #1;
    if (checking)
    begin
      if (proc_resp_v_o && proc_resp_ready_i)
        check_response();
      if (done_seen)
        assert (load_done_o) else report_failure("load_done_o fell after it had risen");
      if (load_done_o && !done_seen)
        check_loaded_words();
      if (load_done_o)
        done_seen = 1'b1;
      if (finish_exp)
        assert (finish_o) else report_failure("finish_o low after a nonzero finish write");
    end
  end

  task automatic apply_backpressure();
    forever
    begin
      @(negedge clk);
      proc_resp_ready_i = (($urandom % 4) != 0);
    end
  endtask

  task automatic watchdog(input int limit);
    repeat (limit) @(posedge clk);
    report_failure($sformatf("Watchdog expired after %0d cycles", limit));
  endtask

  initial
  begin
    void'($urandom(32'h6aea_a17a));
    reset             = 1'b1;
    nbf_i             = '0;
    nbf_v_i           = 1'b0;
    proc_cmd_i        = '0;
    proc_cmd_v_i      = 1'b0;
    proc_resp_ready_i = 1'b1;
    checking          = 1'b0;
    done_seen         = 1'b0;
    finish_exp        = 1'b0;
    enables_exp       = '0;

    $readmemh("verif/harness_golden.txt", golden_r);
    rec_count = -1;
    for (int i = 0; i < max_recs_lp; i++)
    begin
      if (rec_count < 0 && golden_r[3*i][3:0] == end_k)
        rec_count = i;
    end
    assert (rec_count >= 0) else report_failure("Golden file has no end record");

    fork
      watchdog(rec_count * cycles_per_rec_lp + reset_cycles_lp + 64);
    join_none

    repeat (reset_cycles_lp) @(negedge clk);
    reset = 1'b0;
    #1;
    assert (!proc_resp_v_o) else report_mismatch("proc_resp_v_o", 64'd0, 64'(proc_resp_v_o));
    assert (enables_o == '0) else report_mismatch("enables_o", 64'd0, 64'(enables_o));
    assert (!finish_o) else report_mismatch("finish_o", 64'd0, 64'(finish_o));
    assert (!load_done_o) else report_mismatch("load_done_o", 64'd0, 64'(load_done_o));
    checking = 1'b1;

    fork
      apply_backpressure();
    join_none
    fork
      run_loader();
      run_processor();
    join

    while (exp_q.size() != 0)
      @(negedge clk);
    repeat (2) @(negedge clk);
    #1;
    assert (load_done_o) else report_mismatch("load_done_o", 64'd1, 64'(load_done_o));
    assert (finish_o == finish_exp)
      else report_mismatch("finish_o", 64'(finish_exp), 64'(finish_o));
    assert (enables_o == enables_exp)
      else report_mismatch("enables_o", 64'(enables_exp), 64'(enables_o));
    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/harness_golden.txt
// kind addr data; 0 load write, 1 fence, 2 finish, 3 proc write,
// 4 proc read with expected data, 5 wait for load done, f end
0 00000 a5a5000000000001
0 00008 a5a5000000000002
0 00010 a5a5000000000003
1 00000 0000000000000000
0 00018 a5a5000000000004
0 00820 a5a5000000000005
2 00000 0000000000000000
3 00400 1234567800000001
3 00408 1234567800000002
4 00400 1234567800000001
3 00400 1234567800000011
4 00408 1234567800000002
4 00400 1234567800000011
3 f0000 00000000000000a5
4 f0000 00000000000000a5
4 f0010 0000000000000000
5 00000 0000000000000000
4 00000 a5a5000000000001
4 00010 a5a5000000000003
4 00018 a5a5000000000004
4 00020 a5a5000000000005
4 00808 a5a5000000000002
3 f0008 0000000000000001
4 f0008 0000000000000001
f 00000 0000000000000000

// File: filelist.f
hdl/harness_pkg.sv
hdl/nbf_loader.sv
hdl/io_switch.sv
hdl/host_regs.sv
hdl/backing_mem.sv
hdl/harness_top.sv
verif/tb_clock_gen.sv
verif/harness_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds and runs the harness testbench; exit status is nonzero on failure
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -f filelist.f \
       --top-module harness_tb -o harness_sim \
  && ./obj_dir/harness_sim \
  || { echo "simulation did not complete cleanly"; exit 1; }
